// ==== list.f ====
source/scanconv_pkg.sv
source/video_if.sv
source/output_timing_gen.sv
source/line_buffer.sv
source/pixel_postproc.sv
source/scanconverter_top.sv
verif/scanconv_chk.sv
verif/scanconv_tb.sv

// ==== Makefile ====
# Verilator build and run for the scan converter testbench

VERILATOR ?= verilator
TOP       ?= scanconv_tb
BUILD_DIR ?= build
LOG       ?= sim.log
FILELIST  ?= list.f
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000
FAIL_MSG  ?= Test failed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP BUILD_DIR LOG FILELIST VFLAGS SIM_ARGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	@./$(BUILD_DIR)/$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported failure, see $(LOG)"; exit 1; \
	else \
		echo "Simulation clean"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verif/scanconv_tb.sv ====
// Randomized testbench for the scan converter output side
// Fills the line buffer, runs three frames per round and checks against a reference model
`default_nettype none

module scanconv_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import scanconv_pkg::*;

    localparam int NUM_LINES   = DEF_NUM_LINES;
    localparam int LINE_PIXELS = DEF_LINE_PIXELS;
    localparam int ROUNDS      = 6;

    logic                pclk_out;
    logic                rst_n;
    logic                enable;
    logic [COORD_W-1:0]  h_total, h_active, h_synclen, h_backporch;
    logic [COORD_W-1:0]  v_total, v_active, v_synclen, v_backporch;
    logic [RPT_W-1:0]    x_rpt, y_rpt;
    logic                wr_en;
    logic [COORD_W-1:0]  wr_line, wr_x;
    logic [CHAN_W-1:0]   wr_r, wr_g, wr_b;
    logic                sl_enable;
    logic [SL_STR_W-1:0] sl_str;
    logic                testpattern;
    logic                hsync, vsync, de;
    logic [COORD_W-1:0]  xpos, ypos;
    logic [CHAN_W-1:0]   r, g, b;

    // Reference copy of the buffer contents
    rgb_t model_mem [NUM_LINES][LINE_PIXELS];
    int   err_cnt;
    int   timeout_cnt;

    scanconverter_top #(
        .NUM_LINES   (NUM_LINES),
        .LINE_PIXELS (LINE_PIXELS)
    ) dut0 (
        .PCLK_OUT_i (pclk_out), .rst_n_i (rst_n), .enable_i (enable),
        .h_total_i (h_total), .h_active_i (h_active),
        .h_synclen_i (h_synclen), .h_backporch_i (h_backporch),
        .v_total_i (v_total), .v_active_i (v_active),
        .v_synclen_i (v_synclen), .v_backporch_i (v_backporch),
        .x_rpt_i (x_rpt), .y_rpt_i (y_rpt),
        .wr_en_i (wr_en), .wr_line_i (wr_line), .wr_x_i (wr_x),
        .wr_r_i (wr_r), .wr_g_i (wr_g), .wr_b_i (wr_b),
        .sl_enable_i (sl_enable), .sl_str_i (sl_str), .testpattern_i (testpattern),
        .hsync_o (hsync), .vsync_o (vsync), .de_o (de),
        .xpos_o (xpos), .ypos_o (ypos), .r_o (r), .g_o (g), .b_o (b)
    );

    initial begin
        pclk_out = 1'b0;
        forever #50 pclk_out = ~pclk_out;
    end

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'($urandom % 32'(hi - lo + 1));
    endfunction

    // Scanline darkening with saturation at zero
    function automatic logic [CHAN_W-1:0] darken(input logic [CHAN_W-1:0] c, input int amount);
        return (int'(c) > amount) ? CHAN_W'(int'(c) - amount) : '0;
    endfunction

    function automatic rgb_t expected_pixel(input int x, input int y);
        rgb_t p;
        int   amount;
        int   rep_y;
        rep_y = int'(y_rpt) + 1;
        if (testpattern) begin
            p.r = CHAN_W'((x ^ y) & 255);
            p.g = p.r;
            p.b = p.r;
        end else begin
            p = model_mem[(y / rep_y) % NUM_LINES][x / (int'(x_rpt) + 1)];
            if (sl_enable && (y % rep_y) == int'(y_rpt)) begin
                amount = (int'(sl_str) + 1) * 16 - 1;
                p.r = darken(p.r, amount);
                p.g = darken(p.g, amount);
                p.b = darken(p.b, amount);
            end
        end
        return p;
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
        if (exp_v !== act_v) begin
            err_cnt++;
            $display("** Error: %s expected 0x%0h, got 0x%0h at %0t", name, exp_v, act_v, $time);
        end
    endtask

    task automatic expect_idle();
        check_val("hsync_o", 32'd1, 32'(hsync));
        check_val("vsync_o", 32'd1, 32'(vsync));
        check_val("de_o", 32'd0, 32'(de));
        check_val("{r_o, g_o, b_o}", 32'd0, 32'({r, g, b}));
    endtask

    // Mode 0 is plain, mode 1 adds scanlines and mode 2 selects the test pattern
    task automatic pick_config(input int mode);
        int xr, yr, hmax, ha, hs, hb, hf, va, vs, vb, vf;
        xr   = rand_range(0, 3);
        yr   = rand_range(0, 3);
        hmax = LINE_PIXELS * (xr + 1);
        if (hmax > 96) begin
            hmax = 96;
        end
        ha = rand_range(8, hmax);
        hs = rand_range(2, 9);
        hb = rand_range(1, 8);
        hf = rand_range(1, 8);
        va = rand_range(4, 20);
        vs = rand_range(1, 3);
        vb = rand_range(1, 3);
        vf = rand_range(1, 3);
        @(posedge pclk_out);
        x_rpt       <= RPT_W'(xr);
        y_rpt       <= RPT_W'(yr);
        h_active    <= COORD_W'(ha);
        h_synclen   <= COORD_W'(hs);
        h_backporch <= COORD_W'(hb);
        h_total     <= COORD_W'(hs + hb + ha + hf);
        v_active    <= COORD_W'(va);
        v_synclen   <= COORD_W'(vs);
        v_backporch <= COORD_W'(vb);
        v_total     <= COORD_W'(vs + vb + va + vf);
        sl_enable   <= (mode == 1) || (mode == 2 && ($urandom % 2) == 1);
        sl_str      <= SL_STR_W'($urandom % 16);
        testpattern <= (mode == 2);
    endtask

    // Writes every buffer word while the outputs must stay idle
    task automatic fill_buffer();
        rgb_t pix;
        int   n;
        n = 0;
        for (int ln = 0; ln < NUM_LINES; ln++) begin
            for (int x = 0; x < LINE_PIXELS; x++) begin
                pix.r = CHAN_W'($urandom);
                pix.g = CHAN_W'($urandom);
                pix.b = CHAN_W'($urandom);
                model_mem[ln][x] = pix;
                @(posedge pclk_out);
                wr_en   <= 1'b1;
                wr_line <= COORD_W'(ln);
                wr_x    <= COORD_W'(x);
                wr_r    <= pix.r;
                wr_g    <= pix.g;
                wr_b    <= pix.b;
                @(negedge pclk_out);
                // Pipeline still drains for a few cycles after enable drops
                if (n >= 4) begin
                    expect_idle();
                end
                n++;
            end
        end
        @(posedge pclk_out);
        wr_en <= 1'b0;
    endtask

    // Watches three complete frames between four vsync falls
    task automatic run_frames();
        int   cyc, limit, last_hfall, last_vfall, run_len, de_lines, frames_seen;
        logic prev_hs, prev_vs, prev_de;
        rgb_t exp_pix;
        cyc         = 0;
        limit       = 4 * int'(v_total) * int'(h_total) + 64;
        last_hfall  = -1;
        last_vfall  = -1;
        run_len     = 0;
        de_lines    = 0;
        frames_seen = 0;
        prev_hs     = 1'b1;
        prev_vs     = 1'b1;
        prev_de     = 1'b0;
        while (frames_seen < 4 && cyc < limit) begin
            @(negedge pclk_out);
            cyc++;
            if (prev_hs && !hsync) begin
                if (last_hfall >= 0) begin
                    check_val("hsync_o period", 32'(h_total), 32'(cyc - last_hfall));
                end
                last_hfall = cyc;
            end else if (!prev_hs && hsync && last_hfall >= 0) begin
                check_val("hsync_o low", 32'(h_synclen), 32'(cyc - last_hfall));
            end
            if (prev_vs && !vsync) begin
                if (last_vfall >= 0) begin
                    check_val("vsync_o period", 32'(int'(v_total) * int'(h_total)),
                              32'(cyc - last_vfall));
                end
                if (frames_seen > 0) begin
                    check_val("de_o lines", 32'(v_active), 32'(de_lines));
                end
                de_lines = 0;
                frames_seen++;
                last_vfall = cyc;
            end else if (!prev_vs && vsync && last_vfall >= 0) begin
                check_val("vsync_o low", 32'(int'(v_synclen) * int'(h_total)),
                          32'(cyc - last_vfall));
            end
            if (de) begin
                if (!prev_de) begin
                    run_len = 0;
                    check_val("ypos_o", 32'(de_lines), 32'(ypos));
                end
                check_val("xpos_o", 32'(run_len), 32'(xpos));
                check_val("hsync_o", 32'd1, 32'(hsync));
                check_val("vsync_o", 32'd1, 32'(vsync));
                exp_pix = expected_pixel(run_len, de_lines);
                check_val("r_o", 32'(exp_pix.r), 32'(r));
                check_val("g_o", 32'(exp_pix.g), 32'(g));
                check_val("b_o", 32'(exp_pix.b), 32'(b));
                run_len++;
            end else begin
                check_val("{r_o, g_o, b_o}", 32'd0, 32'({r, g, b}));
                if (prev_de) begin
                    check_val("de_o run length", 32'(h_active), 32'(run_len));
                    de_lines++;
                end
            end
            prev_hs = hsync;
            prev_vs = vsync;
            prev_de = de;
        end
        if (frames_seen < 4) begin
            timeout_cnt++;
            $display("Timeout: saw %0d of 4 vsync pulses within %0d cycles", frames_seen, limit);
        end
    endtask

    initial begin
        void'($urandom(32'h59fe778d));
        err_cnt     = 0;
        timeout_cnt = 0;
        rst_n       = 1'b0;
        enable      = 1'b0;
        {h_total, h_active, h_synclen, h_backporch} = '0;
        {v_total, v_active, v_synclen, v_backporch} = '0;
        x_rpt       = '0;
        y_rpt       = '0;
        wr_en       = 1'b0;
        wr_line     = '0;
        wr_x        = '0;
        {wr_r, wr_g, wr_b} = '0;
        sl_enable   = 1'b0;
        sl_str      = '0;
        testpattern = 1'b0;

        for (int i = 0; i < 16; i++) begin
            @(posedge pclk_out);
            if (i == 15) begin
                rst_n <= 1'b1;
            end
            @(negedge pclk_out);
            expect_idle();
        end

        for (int rnd = 0; rnd < ROUNDS; rnd++) begin
            pick_config(rnd % 3);
            fill_buffer();
            @(posedge pclk_out);
            enable <= 1'b1;
            run_frames();
            @(posedge pclk_out);
            enable <= 1'b0;
        end

        $display("Done: %0d mismatches, %0d assertion failures, %0d timeouts",
                 err_cnt, dut0.chk0.fail_cnt, timeout_cnt);
        if (err_cnt == 0 && dut0.chk0.fail_cnt == 0 && timeout_cnt == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/scanconv_chk.sv ====
// Concurrent checks on the top-level video output rules
// Bound into scanconverter_top and read by the testbench through fail_cnt
`default_nettype none

module scanconv_chk (
    input wire logic                            PCLK_OUT_i,
    input wire logic                            rst_n_i,
    input wire logic                            hsync_i,
    input wire logic                            vsync_i,
    input wire logic                            de_i,
    input wire logic [scanconv_pkg::CHAN_W-1:0] r_i,
    input wire logic [scanconv_pkg::CHAN_W-1:0] g_i,
    input wire logic [scanconv_pkg::CHAN_W-1:0] b_i
);
    timeunit 1ns;
    timeprecision 100ps;

    // Assertion failures seen so far
    int fail_cnt = 0;

    // Synchronous reset puts the whole pipeline in its idle state
    idle_after_reset: assert property (
        @(posedge PCLK_OUT_i) !rst_n_i |=> hsync_i && vsync_i && !de_i
    ) else begin
        fail_cnt++;
        $error("sync or DE not idle in the cycle after reset");
    end

    // Active window starts after both sync pulses
    de_outside_sync: assert property (
        @(posedge PCLK_OUT_i) disable iff (!rst_n_i) de_i |-> hsync_i && vsync_i
    ) else begin
        fail_cnt++;
        $error("DE high while a sync pulse is active");
    end

    blank_outside_de: assert property (
        @(posedge PCLK_OUT_i) disable iff (!rst_n_i)
        !de_i |-> (r_i == '0) && (g_i == '0) && (b_i == '0)
    ) else begin
        fail_cnt++;
        $error("RGB not zero outside DE");
    end

endmodule

bind scanconverter_top scanconv_chk chk0 (
    .PCLK_OUT_i (PCLK_OUT_i),
    .rst_n_i    (rst_n_i),
    .hsync_i    (hsync_o),
    .vsync_i    (vsync_o),
    .de_i       (de_o),
    .r_i        (r_o),
    .g_i        (g_o),
    .b_i        (b_o)
);

`default_nettype wire

// ==== source/scanconverter_top.sv ====
// Scan converter output side: timing generator, line buffer and pixel postprocessor
// Configuration must stay stable while enable_i is high
`default_nettype none

module scanconverter_top #(
    parameter int NUM_LINES   = scanconv_pkg::DEF_NUM_LINES,
    parameter int LINE_PIXELS = scanconv_pkg::DEF_LINE_PIXELS
) (
    input  wire logic                               PCLK_OUT_i,
    input  wire logic                               rst_n_i,
    input  wire logic                               enable_i,
    input  wire logic [scanconv_pkg::COORD_W-1:0]   h_total_i,
    input  wire logic [scanconv_pkg::COORD_W-1:0]   h_active_i,
    input  wire logic [scanconv_pkg::COORD_W-1:0]   h_synclen_i,
    input  wire logic [scanconv_pkg::COORD_W-1:0]   h_backporch_i,
    input  wire logic [scanconv_pkg::COORD_W-1:0]   v_total_i,
    input  wire logic [scanconv_pkg::COORD_W-1:0]   v_active_i,
    input  wire logic [scanconv_pkg::COORD_W-1:0]   v_synclen_i,
    input  wire logic [scanconv_pkg::COORD_W-1:0]   v_backporch_i,
    input  wire logic [scanconv_pkg::RPT_W-1:0]     x_rpt_i,
    input  wire logic [scanconv_pkg::RPT_W-1:0]     y_rpt_i,
    input  wire logic                               wr_en_i,
    input  wire logic [scanconv_pkg::COORD_W-1:0]   wr_line_i,
    input  wire logic [scanconv_pkg::COORD_W-1:0]   wr_x_i,
    input  wire logic [scanconv_pkg::CHAN_W-1:0]    wr_r_i,
    input  wire logic [scanconv_pkg::CHAN_W-1:0]    wr_g_i,
    input  wire logic [scanconv_pkg::CHAN_W-1:0]    wr_b_i,
    input  wire logic                               sl_enable_i,
    input  wire logic [scanconv_pkg::SL_STR_W-1:0]  sl_str_i,
    input  wire logic                               testpattern_i,
    output logic                                    hsync_o,
    output logic                                    vsync_o,
    output logic                                    de_o,
    output logic [scanconv_pkg::COORD_W-1:0]        xpos_o,
    output logic [scanconv_pkg::COORD_W-1:0]        ypos_o,
    output logic [scanconv_pkg::CHAN_W-1:0]         r_o,
    output logic [scanconv_pkg::CHAN_W-1:0]         g_o,
    output logic [scanconv_pkg::CHAN_W-1:0]         b_o
);
    import scanconv_pkg::*;

    rgb_t wr_pix;

    video_timing_if tim_if ();
    video_pixel_if  pix_if ();

    assign wr_pix = '{r: wr_r_i, g: wr_g_i, b: wr_b_i};

    output_timing_gen #(
        .NUM_LINES   (NUM_LINES),
        .LINE_PIXELS (LINE_PIXELS)
    ) timing0 (
        .PCLK_OUT_i    (PCLK_OUT_i),
        .rst_n_i       (rst_n_i),
        .enable_i      (enable_i),
        .h_total_i     (h_total_i),
        .h_active_i    (h_active_i),
        .h_synclen_i   (h_synclen_i),
        .h_backporch_i (h_backporch_i),
        .v_total_i     (v_total_i),
        .v_active_i    (v_active_i),
        .v_synclen_i   (v_synclen_i),
        .v_backporch_i (v_backporch_i),
        .x_rpt_i       (x_rpt_i),
        .y_rpt_i       (y_rpt_i),
        .tim_o         (tim_if.src)
    );

    line_buffer #(
        .NUM_LINES   (NUM_LINES),
        .LINE_PIXELS (LINE_PIXELS)
    ) lbuf0 (
        .PCLK_OUT_i (PCLK_OUT_i),
        .rst_n_i    (rst_n_i),
        .wr_en_i    (wr_en_i),
        .wr_line_i  (wr_line_i),
        .wr_x_i     (wr_x_i),
        .wr_pix_i   (wr_pix),
        .tim_i      (tim_if.dst),
        .pix_o      (pix_if.src)
    );

    pixel_postproc pp0 (
        .PCLK_OUT_i    (PCLK_OUT_i),
        .rst_n_i       (rst_n_i),
        .pix_i         (pix_if.dst),
        .sl_enable_i   (sl_enable_i),
        .sl_str_i      (sl_str_i),
        .testpattern_i (testpattern_i),
        .hsync_o       (hsync_o),
        .vsync_o       (vsync_o),
        .de_o          (de_o),
        .xpos_o        (xpos_o),
        .ypos_o        (ypos_o),
        .r_o           (r_o),
        .g_o           (g_o),
        .b_o           (b_o)
    );

endmodule

`default_nettype wire

// ==== source/pixel_postproc.sv ====
// Two-stage pixel postprocessing: scanline darkening, then test pattern and output registers
// RGB is forced to zero outside DE
`default_nettype none

module pixel_postproc (
    input  wire logic                                   PCLK_OUT_i,
    input  wire logic                                   rst_n_i,
    video_pixel_if.dst                                  pix_i,
    input  wire logic                                   sl_enable_i,
    input  wire logic [scanconv_pkg::SL_STR_W-1:0]      sl_str_i,
    input  wire logic                                   testpattern_i,
    output logic                                        hsync_o,
    output logic                                        vsync_o,
    output logic                                        de_o,
    output logic [scanconv_pkg::COORD_W-1:0]            xpos_o,
    output logic [scanconv_pkg::COORD_W-1:0]            ypos_o,
    output logic [scanconv_pkg::CHAN_W-1:0]             r_o,
    output logic [scanconv_pkg::CHAN_W-1:0]             g_o,
    output logic [scanconv_pkg::CHAN_W-1:0]             b_o
);
    import scanconv_pkg::*;

    logic [CHAN_W-1:0]  sl_thold;
    logic               sl_apply;
    logic               s1_hsync;
    logic               s1_vsync;
    logic               s1_de;
    logic [COORD_W-1:0] s1_xpos;
    logic [COORD_W-1:0] s1_ypos;
    rgb_t               s1_pix;
    logic [COORD_W-1:0] tp_val;
    rgb_t               out_pix;

    function automatic logic [CHAN_W-1:0] sat_sub(input logic [CHAN_W-1:0] c,
                                                  input logic [CHAN_W-1:0] t);
        return (c > t) ? c - t : '0;
    endfunction

    // (str+1)*16-1 is the strength in the high nibble with the low nibble all ones
    assign sl_thold = CHAN_W'({sl_str_i, 4'hf});
    assign sl_apply = sl_enable_i && pix_i.sl_line;

    // Stage 1, scanline subtraction
    always_ff @(posedge PCLK_OUT_i) begin
        if (!rst_n_i) begin
            s1_hsync <= 1'b1;
            s1_vsync <= 1'b1;
            s1_de    <= 1'b0;
        end else begin
            s1_hsync <= pix_i.hsync;
            s1_vsync <= pix_i.vsync;
            s1_de    <= pix_i.de;
        end
    end

    always_ff @(posedge PCLK_OUT_i) begin
        s1_xpos <= pix_i.xpos;
        s1_ypos <= pix_i.ypos;
        if (sl_apply) begin
            s1_pix.r <= sat_sub(pix_i.pixel.r, sl_thold);
            s1_pix.g <= sat_sub(pix_i.pixel.g, sl_thold);
            s1_pix.b <= sat_sub(pix_i.pixel.b, sl_thold);
        end else begin
            s1_pix <= pix_i.pixel;
        end
    end

    // Stage 2 source select
    always_comb begin
        tp_val = s1_xpos ^ s1_ypos;
        if (!s1_de) begin
            out_pix = '0;
        end else if (testpattern_i) begin
            out_pix = '{r: tp_val[CHAN_W-1:0], g: tp_val[CHAN_W-1:0], b: tp_val[CHAN_W-1:0]};
        end else begin
            out_pix = s1_pix;
        end
    end

    always_ff @(posedge PCLK_OUT_i) begin
        if (!rst_n_i) begin
            hsync_o <= 1'b1;
            vsync_o <= 1'b1;
            de_o    <= 1'b0;
            r_o     <= '0;
            g_o     <= '0;
            b_o     <= '0;
        end else begin
            hsync_o <= s1_hsync;
            vsync_o <= s1_vsync;
            de_o    <= s1_de;
            r_o     <= out_pix.r;
            g_o     <= out_pix.g;
            b_o     <= out_pix.b;
        end
    end

    always_ff @(posedge PCLK_OUT_i) begin
        xpos_o <= s1_xpos;
        ypos_o <= s1_ypos;
    end

endmodule

`default_nettype wire

// ==== source/line_buffer.sv ====
// Small multi-line pixel store with a same-clock write strobe and a registered read
// Timing fields are delayed one cycle so they stay aligned with the read data
`default_nettype none

module line_buffer #(
    parameter int NUM_LINES   = scanconv_pkg::DEF_NUM_LINES,
    parameter int LINE_PIXELS = scanconv_pkg::DEF_LINE_PIXELS
) (
    input  wire logic                               PCLK_OUT_i,
    input  wire logic                               rst_n_i,
    input  wire logic                               wr_en_i,
    input  wire logic [scanconv_pkg::COORD_W-1:0]   wr_line_i,
    input  wire logic [scanconv_pkg::COORD_W-1:0]   wr_x_i,
    input  wire scanconv_pkg::rgb_t                 wr_pix_i,
    video_timing_if.dst                             tim_i,
    video_pixel_if.src                              pix_o
);
    import scanconv_pkg::*;

    localparam int DEPTH  = NUM_LINES * LINE_PIXELS;
    localparam int ADDR_W = $clog2(DEPTH);

    rgb_t              mem [0:DEPTH-1];
    logic [ADDR_W-1:0] wr_addr;
    logic [ADDR_W-1:0] rd_addr;

    // Line-major layout
    assign wr_addr = ADDR_W'(wr_line_i) * ADDR_W'(LINE_PIXELS) + ADDR_W'(wr_x_i);
    assign rd_addr = ADDR_W'(tim_i.lb_line) * ADDR_W'(LINE_PIXELS) + ADDR_W'(tim_i.lb_x);

    always_ff @(posedge PCLK_OUT_i) begin
        if (wr_en_i) begin
            mem[wr_addr] <= wr_pix_i;
        end
    end

    always_ff @(posedge PCLK_OUT_i) begin
        pix_o.pixel <= mem[rd_addr];
        pix_o.xpos  <= tim_i.xpos;
        pix_o.ypos  <= tim_i.ypos;
    end

    always_ff @(posedge PCLK_OUT_i) begin
        if (!rst_n_i) begin
            pix_o.hsync   <= 1'b1;
            pix_o.vsync   <= 1'b1;
            pix_o.de      <= 1'b0;
            pix_o.sl_line <= 1'b0;
        end else begin
            pix_o.hsync   <= tim_i.hsync;
            pix_o.vsync   <= tim_i.vsync;
            pix_o.de      <= tim_i.de;
            pix_o.sl_line <= tim_i.sl_line;
        end
    end

endmodule

`default_nettype wire

// ==== source/output_timing_gen.sv ====
// Output raster timing: H/V counters, active-low syncs, DE, positions and buffer addressing
// Outputs are registered one cycle after the counters
`default_nettype none

module output_timing_gen #(
    parameter int NUM_LINES   = scanconv_pkg::DEF_NUM_LINES,
    parameter int LINE_PIXELS = scanconv_pkg::DEF_LINE_PIXELS
) (
    input  wire logic                               PCLK_OUT_i,
    input  wire logic                               rst_n_i,
    input  wire logic                               enable_i,
    input  wire logic [scanconv_pkg::COORD_W-1:0]   h_total_i,
    input  wire logic [scanconv_pkg::COORD_W-1:0]   h_active_i,
    input  wire logic [scanconv_pkg::COORD_W-1:0]   h_synclen_i,
    input  wire logic [scanconv_pkg::COORD_W-1:0]   h_backporch_i,
    input  wire logic [scanconv_pkg::COORD_W-1:0]   v_total_i,
    input  wire logic [scanconv_pkg::COORD_W-1:0]   v_active_i,
    input  wire logic [scanconv_pkg::COORD_W-1:0]   v_synclen_i,
    input  wire logic [scanconv_pkg::COORD_W-1:0]   v_backporch_i,
    input  wire logic [scanconv_pkg::RPT_W-1:0]     x_rpt_i,
    input  wire logic [scanconv_pkg::RPT_W-1:0]     y_rpt_i,
    video_timing_if.src                             tim_o
);
    import scanconv_pkg::*;

    localparam logic [COORD_W-1:0] LAST_LINE = COORD_W'(NUM_LINES - 1);
    localparam logic [COORD_W-1:0] LAST_X    = COORD_W'(LINE_PIXELS - 1);

    logic [COORD_W-1:0] h_cnt;
    logic [COORD_W-1:0] v_cnt;
    logic [RPT_W-1:0]   x_ctr;
    logic [RPT_W-1:0]   y_ctr;
    logic [COORD_W-1:0] lb_x_cnt;
    logic [COORD_W-1:0] lb_line_cnt;

    // Window bounds carry one extra bit so start+active cannot wrap
    logic [COORD_W:0]   h_start;
    logic [COORD_W:0]   h_end;
    logic [COORD_W:0]   v_start;
    logic [COORD_W:0]   v_end;
    logic               h_win;
    logic               v_win;
    logic               line_end;
    logic               frame_end;

    assign h_start = {1'b0, h_synclen_i} + {1'b0, h_backporch_i};
    assign h_end   = h_start + {1'b0, h_active_i};
    assign v_start = {1'b0, v_synclen_i} + {1'b0, v_backporch_i};
    assign v_end   = v_start + {1'b0, v_active_i};

    assign h_win = ({1'b0, h_cnt} >= h_start) && ({1'b0, h_cnt} < h_end);
    assign v_win = ({1'b0, v_cnt} >= v_start) && ({1'b0, v_cnt} < v_end);

    assign line_end  = (h_cnt == h_total_i - 1'b1);
    assign frame_end = line_end && (v_cnt == v_total_i - 1'b1);

    // Counters and repeat state, all describing the current h_cnt/v_cnt position
    always_ff @(posedge PCLK_OUT_i) begin
        if (!rst_n_i || !enable_i) begin
            h_cnt       <= '0;
            v_cnt       <= '0;
            x_ctr       <= '0;
            y_ctr       <= '0;
            lb_x_cnt    <= '0;
            lb_line_cnt <= '0;
        end else if (line_end) begin
            h_cnt    <= '0;
            x_ctr    <= '0;
            lb_x_cnt <= '0;
            if (frame_end) begin
                v_cnt       <= '0;
                y_ctr       <= '0;
                lb_line_cnt <= '0;
            end else begin
                v_cnt <= v_cnt + 1'b1;
                // Step to the next buffer line after the last copy of a group
                if (v_win) begin
                    if (y_ctr == y_rpt_i) begin
                        y_ctr       <= '0;
                        lb_line_cnt <= (lb_line_cnt == LAST_LINE) ? '0 : lb_line_cnt + 1'b1;
                    end else begin
                        y_ctr <= y_ctr + 1'b1;
                    end
                end
            end
        end else begin
            h_cnt <= h_cnt + 1'b1;
            if (h_win) begin
                if (x_ctr == x_rpt_i) begin
                    x_ctr <= '0;
                    // Stay on the last stored pixel if the line runs long
                    if (lb_x_cnt != LAST_X) begin
                        lb_x_cnt <= lb_x_cnt + 1'b1;
                    end
                end else begin
                    x_ctr <= x_ctr + 1'b1;
                end
            end
        end
    end

    // Sync and DE, idle levels while stopped
    always_ff @(posedge PCLK_OUT_i) begin
        if (!rst_n_i || !enable_i) begin
            tim_o.hsync   <= 1'b1;
            tim_o.vsync   <= 1'b1;
            tim_o.de      <= 1'b0;
            tim_o.sl_line <= 1'b0;
        end else begin
            tim_o.hsync   <= (h_cnt >= h_synclen_i);
            tim_o.vsync   <= (v_cnt >= v_synclen_i);
            tim_o.de      <= h_win && v_win;
            tim_o.sl_line <= (y_ctr == y_rpt_i);
        end
    end

    // Offsets into the active window and buffer read address
    always_ff @(posedge PCLK_OUT_i) begin
        tim_o.xpos    <= h_cnt - h_start[COORD_W-1:0];
        tim_o.ypos    <= v_cnt - v_start[COORD_W-1:0];
        tim_o.lb_x    <= lb_x_cnt;
        tim_o.lb_line <= lb_line_cnt;
    end

endmodule

`default_nettype wire

// ==== source/video_if.sv ====
// Per-cycle video streams between the timing generator, line buffer and postprocessor
// No handshake, every clock carries one pixel position
`default_nettype none

interface video_timing_if;
    import scanconv_pkg::*;

    logic               hsync;
    logic               vsync;
    logic               de;
    logic [COORD_W-1:0] xpos;
    logic [COORD_W-1:0] ypos;
    logic [COORD_W-1:0] lb_line;
    logic [COORD_W-1:0] lb_x;
    // Last repeated copy of a source line
    logic               sl_line;

    modport src (output hsync, vsync, de, xpos, ypos, lb_line, lb_x, sl_line);
    modport dst (input hsync, vsync, de, xpos, ypos, lb_line, lb_x, sl_line);
endinterface

interface video_pixel_if;
    import scanconv_pkg::*;

    logic               hsync;
    logic               vsync;
    logic               de;
    logic [COORD_W-1:0] xpos;
    logic [COORD_W-1:0] ypos;
    logic               sl_line;
    rgb_t               pixel;

    modport src (output hsync, vsync, de, xpos, ypos, sl_line, pixel);
    modport dst (input hsync, vsync, de, xpos, ypos, sl_line, pixel);
endinterface

`default_nettype wire

// ==== source/scanconv_pkg.sv ====
// Widths, the RGB pixel type and default buffer sizes for the scan converter output path
// Imported by every RTL block and by the testbench reference model
`default_nettype none

package scanconv_pkg;

    // Horizontal and vertical counters, sizes and positions
    localparam int COORD_W = 12;

    // One colour channel
    localparam int CHAN_W = 8;

    // Integer pixel and line repeat counts
    localparam int RPT_W = 4;

    // Scanline strength, applied as (str+1)*16-1
    localparam int SL_STR_W = 4;

    // Line buffer geometry used when the top level is not overridden
    localparam int DEF_NUM_LINES = 8;
    localparam int DEF_LINE_PIXELS = 64;

    // One pixel as stored in the line buffer and carried down the pipeline
    typedef struct packed {
        logic [CHAN_W-1:0] r;
        logic [CHAN_W-1:0] g;
        logic [CHAN_W-1:0] b;
    } rgb_t;

endpackage

`default_nettype wire
